/* hw/switch_config.svh */
`ifndef SWITCH_CONFIG_SVH
`define SWITCH_CONFIG_SVH

// ====================
// Switch dimensions
// ====================

`define PORT_NUM       4                   // Must be a power of two so slot indices wrap
`define QUEUE_DEPTH    4                   // Cells held by each VOQ
`define PAYLOAD_WIDTH  16

`define PORT_IDX_WIDTH $clog2(`PORT_NUM)

`endif

/* hw/switch_pkg.sv */
`include "switch_config.svh"

package switch_pkg;

    typedef logic [`PORT_IDX_WIDTH-1:0] port_idx_t;
    typedef logic [`PORT_NUM-1:0]       port_mask_t;   // One bit per port
    typedef logic [`PAYLOAD_WIDTH-1:0]  payload_t;

    typedef struct packed {
        port_idx_t dest;
        payload_t  payload;
    } in_cell_t;

    typedef struct packed {
        port_idx_t src;                                // Ingress port the cell came from
        port_idx_t dest;
        payload_t  payload;
    } out_cell_t;

    typedef struct packed {
        logic      pop;
        port_idx_t out_sel;                            // Output reading this input in the slot
    } grant_t;

endpackage

/* hw/voq_bank.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module voq_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  switch_pkg::in_cell_t  in_cell,
    input  switch_pkg::grant_t    grant,
    output logic                  in_drop,
    output switch_pkg::port_mask_t empty,
    output switch_pkg::in_cell_t  head [`PORT_NUM-1:0]
);
    import switch_pkg::*;

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`QUEUE_DEPTH + 1);

    port_mask_t full;                                  // Bit d set when the VOQ for d is full

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // ====================
    // One FIFO per destination
    // ====================

    for (genvar d = 0; d < `PORT_NUM; d++) begin : g_voq
        in_cell_t         mem [`QUEUE_DEPTH-1:0];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [CNT_W-1:0] count;
        logic             push;
        logic             pop;

        assign full[d] = (count == CNT_W'(`QUEUE_DEPTH));
        assign push    = in_valid && (in_cell.dest == port_idx_t'(d)) && !full[d];
        assign pop     = grant.pop && (grant.out_sel == port_idx_t'(d));

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) wr_ptr <= ptr_next(wr_ptr);
                if (pop) rd_ptr <= ptr_next(rd_ptr);
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;
                endcase
            end
        end

        always_ff @(posedge clk) begin
            if (push) mem[wr_ptr] <= in_cell;
        end

        assign empty[d] = (count == '0);
        assign head[d]  = mem[rd_ptr];                 // Seen by the crossbar in the grant slot

        // A full queue has wrapped onto its oldest cell, so one more push would overwrite it
        a_no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
            full[d] |-> wr_ptr == rd_ptr);

        // Grants come from the scheduler, which must only pick non-empty queues
        a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
            pop |-> count != '0);
    end

    // ====================
    // Drop report
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_drop <= 1'b0;
        end else begin
            in_drop <= in_valid && full[in_cell.dest];  // Flagged the cycle after the strobe
        end
    end

endmodule

/* hw/slot_pointer.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module slot_pointer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  switch_pkg::port_idx_t  reset_index,
    input  switch_pkg::port_mask_t voq_ready,
    input  logic                   hold,
    output switch_pkg::port_idx_t  ptr,
    output switch_pkg::port_mask_t req
);
    import switch_pkg::*;

    // ====================
    // Rotating input pointer
    // ====================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= reset_index;                        // Slot 0 pairs output j with input j
        end else begin
            ptr <= port_idx_t'(ptr + 1'b1);            // Wraps since the port count is a power of two
        end
    end

    // ====================
    // Request toward the current input
    // ====================

    always_comb begin
        if (voq_ready[ptr] && !hold) begin
            req = port_mask_t'(1) << ptr;
        end else begin
            req = '0;
        end
    end

endmodule

/* hw/mux_ctrl.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module mux_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  switch_pkg::port_mask_t empty [`PORT_NUM-1:0],
    input  switch_pkg::port_mask_t out_hold,
    output switch_pkg::grant_t     grant [`PORT_NUM-1:0],
    output switch_pkg::port_idx_t  xbar_sel [`PORT_NUM-1:0],
    output switch_pkg::port_mask_t xbar_en
);
    import switch_pkg::*;

    port_mask_t ready_col [`PORT_NUM-1:0];              // Per output, bit i set when input i has a cell
    port_mask_t req_row [`PORT_NUM-1:0];                // Per output, one-hot on the chosen input
    port_mask_t req_col [`PORT_NUM-1:0];                // Per input, which output picked it

    // ====================
    // Per output scheduling
    // ====================

    for (genvar j = 0; j < `PORT_NUM; j++) begin : g_out
        for (genvar i = 0; i < `PORT_NUM; i++) begin : g_in
            assign ready_col[j][i] = !empty[i][j];
            assign req_col[i][j]   = req_row[j][i];
        end

        slot_pointer slot_pointer_inst (
            .clk         (clk),
            .rst_n       (rst_n),
            .reset_index (port_idx_t'(j)),
            .voq_ready   (ready_col[j]),
            .hold        (out_hold[j]),
            .ptr         (xbar_sel[j]),
            .req         (req_row[j])
        );

        assign xbar_en[j] = |req_row[j];
    end

    // ====================
    // Per input grant
    // ====================

    for (genvar i = 0; i < `PORT_NUM; i++) begin : g_grant
        port_idx_t sel;

        always_comb begin
            sel = '0;
            for (int j = `PORT_NUM - 1; j >= 0; j--) begin
                if (req_col[i][j]) sel = port_idx_t'(j);   // Lowest set bit wins
            end
        end

        assign grant[i] = '{pop: |req_col[i], out_sel: sel};

        // The rotation is a permutation, so no input is read by two outputs at once
        a_col_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(req_col[i]));
    end

endmodule

/* hw/crossbar.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module crossbar (
    input  logic                   clk,
    input  logic                   rst_n,
    input  switch_pkg::in_cell_t   head [`PORT_NUM-1:0][`PORT_NUM-1:0],
    input  switch_pkg::port_idx_t  xbar_sel [`PORT_NUM-1:0],
    input  switch_pkg::port_mask_t xbar_en,
    output switch_pkg::port_mask_t out_valid,
    output switch_pkg::out_cell_t  out_cell [`PORT_NUM-1:0]
);
    import switch_pkg::*;

    // ====================
    // Output registers
    // ====================

    for (genvar j = 0; j < `PORT_NUM; j++) begin : g_out
        in_cell_t sel_cell;

        assign sel_cell = head[xbar_sel[j]][j];        // Head of VOQ j in the selected input

        always_ff @(posedge clk) begin
            if (xbar_en[j]) begin
                out_cell[j].src     <= xbar_sel[j];
                out_cell[j].dest    <= sel_cell.dest;
                out_cell[j].payload <= sel_cell.payload;
            end
        end

        // VOQ j of every bank only ever holds cells addressed to output j
        a_dest_match: assert property (@(posedge clk) disable iff (!rst_n)
            xbar_en[j] |-> sel_cell.dest == port_idx_t'(j));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= xbar_en;                      // One cycle after the grant
        end
    end

endmodule

/* hw/tdm_switch.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module tdm_switch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  switch_pkg::port_mask_t in_valid,
    input  switch_pkg::in_cell_t   in_cell [`PORT_NUM-1:0],
    input  switch_pkg::port_mask_t out_hold,
    output switch_pkg::port_mask_t in_drop,
    output switch_pkg::port_mask_t out_valid,
    output switch_pkg::out_cell_t  out_cell [`PORT_NUM-1:0]
);
    import switch_pkg::*;

    in_cell_t   head [`PORT_NUM-1:0][`PORT_NUM-1:0];   // By input, then destination
    port_mask_t empty [`PORT_NUM-1:0];
    grant_t     grant [`PORT_NUM-1:0];
    port_idx_t  xbar_sel [`PORT_NUM-1:0];
    port_mask_t xbar_en;

    // ====================
    // Ingress queues
    // ====================

    for (genvar i = 0; i < `PORT_NUM; i++) begin : g_in
        voq_bank voq_bank_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .in_valid (in_valid[i]),
            .in_cell  (in_cell[i]),
            .grant    (grant[i]),
            .in_drop  (in_drop[i]),
            .empty    (empty[i]),
            .head     (head[i])
        );
    end

    // ====================
    // Scheduler and fabric
    // ====================

    mux_ctrl mux_ctrl_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .empty    (empty),
        .out_hold (out_hold),
        .grant    (grant),
        .xbar_sel (xbar_sel),
        .xbar_en  (xbar_en)
    );

    crossbar crossbar_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .head      (head),
        .xbar_sel  (xbar_sel),
        .xbar_en   (xbar_en),
        .out_valid (out_valid),
        .out_cell  (out_cell)
    );

endmodule

/* dv/tdm_switch_tb.sv */
`timescale 1ns/1ps
`include "switch_config.svh"

module tdm_switch_tb;
    import switch_pkg::*;

    localparam int          N             = `PORT_NUM;
    localparam int          DEPTH         = `QUEUE_DEPTH;
    localparam logic [31:0] SEED          = 32'h46ad_87cd;
    localparam int          DRAIN_LIMIT   = 200;
    localparam int          RANDOM_CYCLES = 400;
    localparam int          HELD_OUT      = N - 1;
    localparam int          DROP_OUT      = 1 % N;

    logic        clk;
    logic        rst_n;
    port_mask_t  in_valid;
    in_cell_t    in_cell [N-1:0];
    port_mask_t  out_hold;
    port_mask_t  in_drop;
    port_mask_t  out_valid;
    out_cell_t   out_cell [N-1:0];

    logic [31:0] lfsr;
    int          pushed = 0;
    int          delivered = 0;
    int          dropped = 0;

    payload_t    ref_mem [N][N][DEPTH];                // Indexed by input, then output
    int          ref_rd [N][N];
    int          ref_cnt [N][N];
    int          slot_k;
    port_mask_t  exp_valid = '0;
    port_mask_t  exp_drop = '0;
    out_cell_t   exp_cell [N];

    tdm_switch tdm_switch_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_cell   (in_cell),
        .out_hold  (out_hold),
        .in_drop   (in_drop),
        .out_valid (out_valid),
        .out_cell  (out_cell)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // ====================
    // Reference model
    // ====================

    function automatic void predict_cycle();
        logic accept [N];
        int   d;
        int   src;
        for (int i = 0; i < N; i++) begin
            d           = int'(in_cell[i].dest);
            accept[i]   = in_valid[i] && (ref_cnt[i][d] < DEPTH);  // Space counted before pops
            exp_drop[i] = in_valid[i] && !accept[i];
        end
        for (int j = 0; j < N; j++) begin
            src          = (j + slot_k) % N;               // Slot k pairs output j with input j + k
            exp_valid[j] = (ref_cnt[src][j] > 0) && !out_hold[j];
            if (exp_valid[j]) begin
                exp_cell[j] = '{src: port_idx_t'(src), dest: port_idx_t'(j),
                                payload: ref_mem[src][j][ref_rd[src][j]]};
                ref_rd[src][j] = (ref_rd[src][j] + 1) % DEPTH;
                ref_cnt[src][j]--;
            end
        end
        for (int i = 0; i < N; i++) begin
            d = int'(in_cell[i].dest);
            if (accept[i]) begin
                ref_mem[i][d][(ref_rd[i][d] + ref_cnt[i][d]) % DEPTH] = in_cell[i].payload;
                ref_cnt[i][d]++;
            end
        end
        slot_k++;
    endfunction

    function automatic int queued_cells();
        int total;
        total = 0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                total += ref_cnt[i][j];
            end
        end
        return total;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_valid = '0;
            exp_drop  = '0;
            slot_k    = 0;
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    ref_rd[i][j]  = 0;
                    ref_cnt[i][j] = 0;
                end
            end
        end else begin
            predict_cycle();
        end
    end

    // ====================
    // Comparison
    // ====================

    always @(negedge clk) begin
        assert (out_valid === exp_valid) else begin
            $display("MISMATCH time=%0t signal=out_valid expected=%b actual=%b",
                     $time, exp_valid, out_valid);
            stop_on_error();
        end
        assert (in_drop === exp_drop) else begin
            $display("MISMATCH time=%0t signal=in_drop expected=%b actual=%b",
                     $time, exp_drop, in_drop);
            stop_on_error();
        end
        for (int j = 0; j < N; j++) begin
            if (exp_valid[j]) begin
                assert (out_cell[j] === exp_cell[j]) else begin
                    $display("MISMATCH time=%0t signal=out_cell[%0d] expected=%h actual=%h",
                             $time, j, exp_cell[j], out_cell[j]);
                    stop_on_error();
                end
            end
        end
        delivered += $countones(out_valid);
        dropped   += $countones(in_drop);
    end

    // ====================
    // Stimulus
    // ====================

    task automatic next_cycle();
        @(posedge clk);
        in_valid <= '0;
    endtask

    task automatic strobe(input int i, input int d, input payload_t p);
        in_valid[i] <= 1'b1;
        in_cell[i]  <= '{dest: port_idx_t'(d), payload: p};
        pushed++;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        next_cycle();
        out_hold <= '0;
        @(negedge clk);
        while (queued_cells() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (queued_cells() != 0) begin
            $display("Timeout: %0d cells still queued after %0d cycles",
                     queued_cells(), DRAIN_LIMIT);
            stop_on_error();
        end
    endtask

    initial begin
        int       base_drops;
        int       d;
        payload_t p;
        rst_n    = 1'b0;
        in_valid = '0;
        out_hold = '0;
        lfsr     = SEED;
        for (int i = 0; i < N; i++) begin
            in_cell[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (out_valid === '0 && in_drop === '0) else begin
            $display("out_valid or in_drop is not low after reset");
            stop_on_error();
        end

        for (int i = 0; i < N; i++) begin                  // Each input sends one cell into an empty switch
            next_cycle();
            strobe(i, (3 * i + 2) % N, payload_t'(16'hc000 + i));
            wait_drain();
        end

        next_cycle();
        out_hold <= port_mask_t'(1) << HELD_OUT;
        for (int c = 0; c < 2 * N; c++) begin
            next_cycle();
            if (c < N) strobe(c, HELD_OUT, payload_t'(16'h4000 + c));
        end
        wait_drain();

        next_cycle();
        base_drops = dropped;
        out_hold <= port_mask_t'(1) << DROP_OUT;
        for (int c = 0; c < DEPTH + 2; c++) begin
            next_cycle();
            strobe(0, DROP_OUT, payload_t'(16'h5000 + c));
        end
        next_cycle();
        next_cycle();
        assert (dropped - base_drops == 2) else begin
            $display("MISMATCH time=%0t signal=in_drop_count expected=2 actual=%0d",
                     $time, dropped - base_drops);
            stop_on_error();
        end
        wait_drain();

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            next_cycle();
            for (int i = 0; i < N; i++) begin
                if (take_bits(1) == 32'd1) begin
                    d = int'(take_bits(`PORT_IDX_WIDTH));
                    p = payload_t'(take_bits(`PAYLOAD_WIDTH));
                    strobe(i, d, p);
                end
            end
            for (int j = 0; j < N; j++) begin
                out_hold[j] <= (take_bits(3) == 32'd0);    // Roughly one cycle in eight held
            end
        end
        wait_drain();

        next_cycle();
        assert (delivered + dropped == pushed) else begin
            $display("MISMATCH time=%0t signal=cell_count expected=%0d actual=%0d",
                     $time, pushed, delivered + dropped);
            stop_on_error();
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* tdm_switch.f */
+incdir+hw
hw/switch_pkg.sv
hw/voq_bank.sv
hw/slot_pointer.sv
hw/mux_ctrl.sv
hw/crossbar.sv
hw/tdm_switch.sv
dv/tdm_switch_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tdm_switch testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert \
    --top-module tdm_switch_tb -f tdm_switch.f -o sim_tdm_switch
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tdm_switch > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
    echo "No result found in $LOG"
    exit 1
fi
exit 0
